// ==== hw/mem_consts.svh ====
`ifndef MEM_CONSTS_SVH
`define MEM_CONSTS_SVH

// register and data width
`define MEM_XLEN 64

// register number width
`define MEM_REGNO_W 5

// bytes per doubleword and byte offset width
`define MEM_BYTES 8
`define MEM_OFFS_W 3

// doubleword address bits of the data RAM, 256 entries
`define MEM_RAM_AW_DEFAULT 8

`endif

// ==== hw/mem_pkg.sv ====
`include "mem_consts.svh"

package mem_pkg;

  typedef enum logic [3:0] {
    op_other = 4'd0,
    op_lb,
    op_lbu,
    op_lh,
    op_lhu,
    op_lw,
    op_lwu,
    op_ld,
    op_sb,
    op_sh,
    op_sw,
    op_sd
  } mem_op_e;

  typedef enum logic {
    acc_idle,
    acc_wait_data
  } acc_state_e;

  typedef struct packed {
    mem_op_e                  op;
    logic [`MEM_XLEN-1:0]     alu_result;  // address for loads and stores
    logic [`MEM_XLEN-1:0]     rs2_value;
    logic [`MEM_REGNO_W-1:0]  rd_regno;
    logic                     update_rd;
    logic                     branch_taken;
    logic                     mm_load;
    logic [`MEM_XLEN-1:0]     pc_target;
  } stage_in_t;

  typedef struct packed {
    mem_op_e                  op;
    logic [`MEM_XLEN-1:0]     alu_result;
    logic [`MEM_XLEN-1:0]     rs2_value;
    logic [`MEM_REGNO_W-1:0]  rd_regno;
    logic                     update_rd;
    logic                     branch_taken;
    logic                     mm_load;
    logic [`MEM_XLEN-1:0]     pc_target;
    logic [`MEM_XLEN-1:0]     mdata;
  } stage_out_t;

  typedef struct packed {
    logic                               en;
    logic                               write;
    logic [`MEM_XLEN-`MEM_OFFS_W-1:0]   dw_addr;  // cut down by the RAM
    logic [`MEM_XLEN-1:0]               wdata;
    logic [`MEM_BYTES-1:0]              byte_en;
  } mem_req_t;

  function automatic logic op_is_load(mem_op_e op);
    return op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
  endfunction

  function automatic logic op_is_store(mem_op_e op);
    return op inside {op_sb, op_sh, op_sw, op_sd};
  endfunction

  // log2 of the access size in bytes
  function automatic logic [1:0] op_size(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 2'd0;
      op_lh, op_lhu, op_sh: return 2'd1;
      op_lw, op_lwu, op_sw: return 2'd2;
      default:              return 2'd3;
    endcase
  endfunction

endpackage

// ==== hw/mem_access_ctrl.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_access_ctrl (
  input  logic                clk,
  input  logic                reset,
  input  logic                enable,
  input  logic                flush,
  input  mem_pkg::stage_in_t  stage_in,
  output mem_pkg::mem_req_t   mem_req,
  output logic                ready
);
  import mem_pkg::*;

  acc_state_e              state;
  acc_state_e              state_next;
  logic                    is_load;
  logic                    is_store;
  logic [1:0]              size;
  logic [`MEM_OFFS_W-1:0]  offs;
  logic [`MEM_BYTES-1:0]   size_mask;
  logic                    issue;

  assign is_load  = op_is_load(stage_in.op);
  assign is_store = op_is_store(stage_in.op);
  assign size     = op_size(stage_in.op);

  // low offset bits below the access size are dropped
  assign offs = stage_in.alu_result[`MEM_OFFS_W-1:0] & ({`MEM_OFFS_W{1'b1}} << size);

  always_comb begin
    case (size)
      2'd0:    size_mask = 8'h01;
      2'd1:    size_mask = 8'h03;
      2'd2:    size_mask = 8'h0f;
      default: size_mask = 8'hff;
    endcase
  end

  // stores go straight through, loads issue once from idle
  assign issue = enable && !flush && (is_store || (is_load && state == acc_idle));

  always_comb begin
    mem_req.en      = issue;
    mem_req.write   = is_store;
    mem_req.dw_addr = stage_in.alu_result[`MEM_XLEN-1:`MEM_OFFS_W];
    mem_req.wdata   = stage_in.rs2_value << {offs, 3'b000};  // move to byte lane
    mem_req.byte_en = size_mask << offs;
  end

  always_comb begin
    state_next = state;
    case (state)
      acc_idle: begin
        if (issue && is_load) begin
          state_next = acc_wait_data;
        end
      end
      acc_wait_data: begin
        state_next = acc_idle;  // read data is back after one cycle
      end
      default: begin
        state_next = acc_idle;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= acc_idle;
    end else begin
      state <= state_next;
    end
  end

  // only a load still waiting for its read holds the producer
  assign ready = flush || !is_load || (state == acc_wait_data);

endmodule

// ==== hw/data_ram.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module data_ram #(
  parameter int RAM_AW = `MEM_RAM_AW_DEFAULT
) (
  input  logic               clk,
  input  mem_pkg::mem_req_t  mem_req,
  output logic [`MEM_XLEN-1:0] rdata
);

  logic [`MEM_XLEN-1:0] mem [2**RAM_AW];
  logic [RAM_AW-1:0]    addr;

  assign addr = mem_req.dw_addr[RAM_AW-1:0];  // upper address bits wrap

  always_ff @(posedge clk) begin
    if (mem_req.en && mem_req.write) begin
      for (int i = 0; i < `MEM_BYTES; i++) begin
        if (mem_req.byte_en[i]) begin
          mem[addr][i*8 +: 8] <= mem_req.wdata[i*8 +: 8];
        end
      end
    end
  end

  // registered read, one cycle
  always_ff @(posedge clk) begin
    if (mem_req.en && !mem_req.write) begin
      rdata <= mem[addr];
    end
  end

endmodule

// ==== hw/load_align.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module load_align (
  input  mem_pkg::mem_op_e          op,
  input  logic [`MEM_OFFS_W-1:0]    offset,
  input  logic [`MEM_XLEN-1:0]      rdata,
  output logic [`MEM_XLEN-1:0]      load_value
);
  import mem_pkg::*;

  logic [`MEM_OFFS_W-1:0] offs;
  logic [`MEM_XLEN-1:0]   field;

  // align down to the access size, then bring the field to bit 0
  assign offs  = offset & ({`MEM_OFFS_W{1'b1}} << op_size(op));
  assign field = rdata >> {offs, 3'b000};

  always_comb begin
    case (op)
      op_lb: begin
        load_value = {{(`MEM_XLEN-8){field[7]}}, field[7:0]};
      end
      op_lbu: begin
        load_value = {{(`MEM_XLEN-8){1'b0}}, field[7:0]};
      end
      op_lh: begin
        load_value = {{(`MEM_XLEN-16){field[15]}}, field[15:0]};
      end
      op_lhu: begin
        load_value = {{(`MEM_XLEN-16){1'b0}}, field[15:0]};
      end
      op_lw: begin
        load_value = {{(`MEM_XLEN-32){field[31]}}, field[31:0]};
      end
      op_lwu: begin
        load_value = {{(`MEM_XLEN-32){1'b0}}, field[31:0]};
      end
      op_ld: begin
        load_value = rdata;  // whole doubleword
      end
      default: begin
        load_value = '0;  // stores and other ops
      end
    endcase
  end

endmodule

// ==== hw/mem_wb_reg.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_wb_reg (
  input  logic                  clk,
  input  logic                  reset,
  input  logic                  enable,
  input  logic                  flush,
  input  logic                  ready,
  input  mem_pkg::stage_in_t    stage_in,
  input  logic [`MEM_XLEN-1:0]  load_value,
  output mem_pkg::stage_out_t   stage_out
);

  always_ff @(posedge clk) begin
    if (reset || flush) begin
      stage_out <= '0;  // bubble into write-back
    end else if (enable && ready) begin
      stage_out.op           <= stage_in.op;
      stage_out.alu_result   <= stage_in.alu_result;
      stage_out.rs2_value    <= stage_in.rs2_value;
      stage_out.rd_regno     <= stage_in.rd_regno;
      stage_out.update_rd    <= stage_in.update_rd;
      stage_out.branch_taken <= stage_in.branch_taken;
      stage_out.mm_load      <= stage_in.mm_load;
      stage_out.pc_target    <= stage_in.pc_target;
      stage_out.mdata        <= load_value;
    end
  end

endmodule

// ==== hw/mem_stage_top.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_stage_top #(
  parameter int RAM_AW = `MEM_RAM_AW_DEFAULT
) (
  input  logic                 clk,
  input  logic                 reset,
  input  logic                 enable,
  input  logic                 flush,
  input  mem_pkg::stage_in_t   stage_in,
  output logic                 ready,
  output mem_pkg::stage_out_t  stage_out
);
  import mem_pkg::*;

  mem_req_t              mem_req;
  logic [`MEM_XLEN-1:0]  rdata;
  logic [`MEM_XLEN-1:0]  load_value;

  mem_access_ctrl u_ctrl (
    .clk      (clk),
    .reset    (reset),
    .enable   (enable),
    .flush    (flush),
    .stage_in (stage_in),
    .mem_req  (mem_req),
    .ready    (ready)
  );

  data_ram #(
    .RAM_AW (RAM_AW)
  ) u_ram (
    .clk     (clk),
    .mem_req (mem_req),
    .rdata   (rdata)
  );

  // offset is taken straight from the address, no translation
  load_align u_align (
    .op         (stage_in.op),
    .offset     (stage_in.alu_result[`MEM_OFFS_W-1:0]),
    .rdata      (rdata),
    .load_value (load_value)
  );

  mem_wb_reg u_wb_reg (
    .clk        (clk),
    .reset      (reset),
    .enable     (enable),
    .flush      (flush),
    .ready      (ready),
    .stage_in   (stage_in),
    .load_value (load_value),
    .stage_out  (stage_out)
  );

endmodule

// ==== tests/mem_stage_chk.sv ====
`timescale 1ns/1ns

module mem_stage_chk (
  input logic                 clk,
  input logic                 reset,
  input logic                 enable,
  input logic                 flush,
  input mem_pkg::stage_in_t   stage_in,
  input mem_pkg::mem_req_t    mem_req,
  input mem_pkg::acc_state_e  state,
  input logic                 ready
);
  import mem_pkg::*;

  logic is_load;

  assign is_load = stage_in.op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};

  // only a load still waiting in idle may stall
  stall_only_on_load: assert property (
    @(posedge clk) disable iff (reset)
    !ready |-> (is_load && state == acc_idle && !flush)
  ) else $error("ready low outside a pending load");

  wait_one_cycle: assert property (
    @(posedge clk) disable iff (reset)
    state == acc_wait_data |=> state == acc_idle
  ) else $error("acc_wait_data held longer than one cycle");

  no_blocked_write: assert property (
    @(posedge clk) disable iff (reset)
    (mem_req.en && mem_req.write) |-> (enable && !flush)
  ) else $error("memory write while flushed or disabled");

endmodule

bind mem_access_ctrl mem_stage_chk u_chk (
  .clk      (clk),
  .reset    (reset),
  .enable   (enable),
  .flush    (flush),
  .stage_in (stage_in),
  .mem_req  (mem_req),
  .state    (state),
  .ready    (ready)
);

// ==== tests/mem_stage_tb.sv ====
`timescale 1ns/1ns
`include "mem_consts.svh"

module mem_stage_tb;
  import mem_pkg::*;

  localparam int TIMEOUT  = 20;
  localparam int NUM_ROWS = 32;

  typedef struct packed {
    mem_op_e     op;
    logic [2:0]  offset;
    logic        new_addr;  // pick a fresh doubleword
    logic        flush;
    logic        check;
  } row_t;

  logic        clk;
  logic        reset;
  logic        enable;
  logic        flush;
  stage_in_t   stage_in;
  logic        ready;
  stage_out_t  stage_out;

  logic [15:0] lfsr = 16'd45099;
  logic [7:0]  model_mem [64];  // byte model of 8 doublewords
  int          errors;
  int          checks;
  int          tests;
  logic        timed_out;
  logic [2:0]  cur_dw;

  // partial stores run from the top byte down so a wide mask hits earlier bytes
  row_t rows [NUM_ROWS] = '{
    '{op_sd,    3'd0, 1'b1, 1'b0, 1'b1},
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_sb,    3'd7, 1'b1, 1'b0, 1'b0},
    '{op_sb,    3'd6, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd5, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd4, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd3, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd2, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd1, 1'b0, 1'b0, 1'b0},
    '{op_sb,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_sh,    3'd6, 1'b1, 1'b0, 1'b1},
    '{op_sh,    3'd4, 1'b0, 1'b0, 1'b1},
    '{op_sh,    3'd2, 1'b0, 1'b0, 1'b1},
    '{op_sh,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_sw,    3'd4, 1'b1, 1'b0, 1'b1},
    '{op_sw,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_lb,    3'd3, 1'b1, 1'b0, 1'b1},
    '{op_lbu,   3'd3, 1'b0, 1'b0, 1'b1},
    '{op_lh,    3'd5, 1'b0, 1'b0, 1'b1},  // reads the half at 4
    '{op_lhu,   3'd3, 1'b0, 1'b0, 1'b1},
    '{op_lw,    3'd6, 1'b0, 1'b0, 1'b1},
    '{op_lwu,   3'd7, 1'b0, 1'b0, 1'b1},
    '{op_lb,    3'd7, 1'b0, 1'b0, 1'b1},
    '{op_ld,    3'd5, 1'b0, 1'b0, 1'b1},
    '{op_other, 3'd0, 1'b1, 1'b0, 1'b1},
    '{op_sd,    3'd0, 1'b1, 1'b1, 1'b1},  // flushed store
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1},
    '{op_sw,    3'd3, 1'b1, 1'b0, 1'b1},
    '{op_ld,    3'd0, 1'b0, 1'b0, 1'b1}
  };

  mem_stage_top UUT (
    .clk       (clk),
    .reset     (reset),
    .enable    (enable),
    .flush     (flush),
    .stage_in  (stage_in),
    .ready     (ready),
    .stage_out (stage_out)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #4 clk = ~clk;
    end
  end

  // fibonacci lfsr with taps 16 14 13 11
  function automatic logic [63:0] rand_bits(int n);
    logic [63:0] v;
    logic        fb;
    v = '0;
    for (int i = 0; i < n; i++) begin
      fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
      lfsr = {lfsr[14:0], fb};
      v    = {v[62:0], fb};
    end
    return v;
  endfunction

  function automatic int access_bytes(mem_op_e op);
    case (op)
      op_lb, op_lbu, op_sb: return 1;
      op_lh, op_lhu, op_sh: return 2;
      op_lw, op_lwu, op_sw: return 4;
      default:              return 8;
    endcase
  endfunction

  function automatic logic [63:0] load_model(mem_op_e op, logic [2:0] dw, logic [2:0] offset);
    int          n;
    int          base;
    logic [63:0] v;
    n    = access_bytes(op);
    base = (int'(offset) / n) * n;  // aligned down
    v    = '0;
    for (int i = 0; i < n; i++) begin
      v[i*8 +: 8] = model_mem[int'(dw)*8 + base + i];
    end
    if ((op inside {op_lb, op_lh, op_lw}) && v[n*8-1]) begin
      for (int i = n*8; i < 64; i++) begin
        v[i] = 1'b1;
      end
    end
    return v;
  endfunction

  task automatic store_model(input mem_op_e op, input logic [2:0] dw,
                             input logic [2:0] offset, input logic [63:0] data);
    int n;
    int base;
    n    = access_bytes(op);
    base = (int'(offset) / n) * n;
    for (int i = 0; i < n; i++) begin
      model_mem[int'(dw)*8 + base + i] = data[i*8 +: 8];
    end
  endtask

  task automatic compare(input string what, input logic [63:0] got, input logic [63:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic apply_row(input mem_op_e op, input logic [2:0] dw,
                           input logic [2:0] offset, input logic fl, input logic check);
    stage_in_t   si;
    stage_out_t  exp;
    logic        is_load;
    logic        rdy;
    int          cycles;
    int          errs_before;
    is_load       = op inside {op_lb, op_lbu, op_lh, op_lhu, op_lw, op_lwu, op_ld};
    si.op         = op;
    si.alu_result = (rand_bits(8) << 11) | {58'd0, dw, offset};  // bits above the RAM
    si.rs2_value  = rand_bits(64);
    si.rd_regno   = `MEM_REGNO_W'(rand_bits(`MEM_REGNO_W));
    {si.update_rd, si.branch_taken, si.mm_load} = 3'(rand_bits(3));
    si.pc_target  = rand_bits(64);

    exp = '0;
    if (!fl) begin
      exp.op           = si.op;
      exp.alu_result   = si.alu_result;
      exp.rs2_value    = si.rs2_value;
      exp.rd_regno     = si.rd_regno;
      exp.update_rd    = si.update_rd;
      exp.branch_taken = si.branch_taken;
      exp.mm_load      = si.mm_load;
      exp.pc_target    = si.pc_target;
      exp.mdata        = is_load ? load_model(op, dw, offset) : 64'd0;
    end
    errs_before = errors;

    @(negedge clk);
    stage_in = si;
    flush    = fl;
    enable   = 1'b1;
    cycles   = 0;
    rdy      = 1'b0;
    while (!rdy && cycles < TIMEOUT) begin
      #2;
      rdy = ready;  // settled in the low phase
      @(posedge clk);
      @(negedge clk);
      cycles++;
    end
    enable = 1'b0;
    flush  = 1'b0;

    if (!rdy) begin
      errors++;
      timed_out = 1'b1;
      $display("timeout: stage never became ready for %s at %0t", op.name(), $time);
    end else begin
      compare("capture cycles", 64'(cycles), (is_load && !fl) ? 64'd2 : 64'd1);
      if (check) begin
        tests++;
        compare("op", 64'(stage_out.op), 64'(exp.op));
        compare("alu_result", stage_out.alu_result, exp.alu_result);
        compare("rs2_value", stage_out.rs2_value, exp.rs2_value);
        compare("rd_regno", 64'(stage_out.rd_regno), 64'(exp.rd_regno));
        compare("flags", 64'({stage_out.update_rd, stage_out.branch_taken, stage_out.mm_load}),
                64'({exp.update_rd, exp.branch_taken, exp.mm_load}));
        compare("pc_target", stage_out.pc_target, exp.pc_target);
        compare("mdata", stage_out.mdata, exp.mdata);
        $display("test %0d %s dw %0d offset %0d flush %0b %s", tests, op.name(), dw, offset,
                 fl, (errors == errs_before) ? "ok" : "failed");
      end
      if (!fl && (op inside {op_sb, op_sh, op_sw, op_sd})) begin
        store_model(op, dw, offset, si.rs2_value);
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    enable    = 1'b0;
    flush     = 1'b0;
    stage_in  = '0;
    errors    = 0;
    checks    = 0;
    tests     = 0;
    timed_out = 1'b0;
    cur_dw    = '0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    tests++;
    compare("reset ready", 64'(ready), 64'd1);
    compare("reset ctrl fields", 64'({stage_out.op, stage_out.rd_regno, stage_out.update_rd,
            stage_out.branch_taken, stage_out.mm_load}), 64'd0);
    compare("reset alu_result", stage_out.alu_result, 64'd0);
    compare("reset rs2_value", stage_out.rs2_value, 64'd0);
    compare("reset pc_target", stage_out.pc_target, 64'd0);
    compare("reset mdata", stage_out.mdata, 64'd0);
    $display("test %0d reset %s", tests, (errors == 0) ? "ok" : "failed");

    // RAM has no reset, fill the tested doublewords first
    for (int d = 0; d < 8 && !timed_out; d++) begin
      apply_row(op_sd, 3'(d), 3'd0, 1'b0, 1'b0);
    end

    for (int r = 0; r < NUM_ROWS && !timed_out; r++) begin
      if (rows[r].new_addr) begin
        cur_dw = 3'(rand_bits(3));
      end
      apply_row(rows[r].op, cur_dw, rows[r].offset, rows[r].flush, rows[r].check);
    end

    $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0 && !timed_out) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// ==== files.f ====
+incdir+hw
hw/mem_pkg.sv
hw/mem_access_ctrl.sv
hw/data_ram.sv
hw/load_align.sv
hw/mem_wb_reg.sv
hw/mem_stage_top.sv
tests/mem_stage_chk.sv
tests/mem_stage_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the memory stage testbench with Verilator

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
  -f files.f --top-module mem_stage_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

./obj_dir/Vmem_stage_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -q "CHECKS FAILED" "$LOG"; then
  exit 1
fi
exit 0
